// ==== Makefile ====
# Verilator build and run for the packet buffer front end

VERILATOR ?= verilator
TOP       ?= tb_sram_fifo
RTL_TOP   ?= sram_fifo_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== buffer_arbiter.sv ====
// round-robin arbiter from the per-port queues onto the buffer write port
`timescale 1ns/10ps
`include "sram_fifo_params.svh"

module buffer_arbiter
    import stream_pkg::*;
    import buffer_pkg::*;
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic      [`SF_NUM_PORTS-1:0]      q_valid,
    input  mem_word_t [`SF_NUM_PORTS-1:0]      q_word,
    output logic      [`SF_NUM_PORTS-1:0]      q_ready,
    output logic                               bw_en,
    output port_id_t                           bw_port,
    output mem_word_t                          bw_word
);

    localparam int NUM = `SF_NUM_PORTS;

    port_id_t last_grant;
    port_id_t grant;
    logic     found;

    // search starts one past the last winner
    always_comb
    begin
        int idx;
        found = 1'b0;
        grant = last_grant;
        for (int i = 1; i <= NUM; i++)
        begin
            idx = (int'(last_grant) + i) % NUM;
            if (!found && q_valid[idx])
            begin
                found = 1'b1;
                grant = port_id_t'(idx);
            end
        end
    end

    // write lands in the grant cycle
    assign bw_en   = found;
    assign bw_port = grant;
    assign bw_word = q_word[grant];

    always_comb
    begin
        q_ready = '0;
        if (found)
            q_ready[grant] = 1'b1;
    end

    // pointer at the top port so port 0 goes first
    always_ff @(posedge clk)
    begin
        if (reset)
            last_grant <= port_id_t'(NUM - 1);
        else if (found)
            last_grant <= grant;
    end

endmodule

// ==== buffer_pkg.sv ====
// buffer side types: tagged buffer word, egress word, address and credit
`include "sram_fifo_params.svh"

package buffer_pkg;

    import stream_pkg::*;

    // 24-bit payload plus the packing phase that made it
    // last marks the final word of a packet
    typedef struct packed {
        logic [`SF_WORD_BITS-1:0] data;
        logic [1:0]               phase;
        logic                     last;
    } mem_word_t;

    // egress word tagged with its source port
    typedef struct packed {
        port_id_t  port;
        mem_word_t word;
    } out_word_t;

    // offset inside one ring region
    typedef logic [$clog2(`SF_QUEUE_WORDS)-1:0] buf_off_t;

    // region select on top, offset below
    typedef struct packed {
        port_id_t port;
        buf_off_t offset;
    } buf_addr_t;

    // free words in a region, holds 0 up to SF_QUEUE_WORDS
    typedef logic [$clog2(`SF_QUEUE_WORDS+1)-1:0] credit_t;

endpackage

// ==== packet_buffer.sv ====
// shared buffer memory with one ring region per port, drained by the selected reader port
`timescale 1ns/10ps
`include "sram_fifo_params.svh"

module packet_buffer
    import stream_pkg::*;
    import buffer_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      bw_en,
    input  port_id_t                  bw_port,
    input  mem_word_t                 bw_word,
    input  port_id_t                  rd_port,
    output logic                      eg_valid,
    output out_word_t                 eg_word,
    input  logic                      eg_almost_full,
    output logic [`SF_NUM_PORTS-1:0]  free
);

    localparam int NUM = `SF_NUM_PORTS;

    mem_word_t mem [2**$bits(buf_addr_t)];

    // ring state per region
    buf_off_t  head [NUM];
    buf_off_t  tail [NUM];
    credit_t   fill [NUM];

    buf_addr_t wr_addr;
    buf_addr_t rd_addr;
    logic      move;
    logic [NUM-1:0] wr_hit;

    assign wr_addr = '{port: bw_port, offset: tail[bw_port]};
    assign rd_addr = '{port: rd_port, offset: head[rd_port]};

    ////////////////////////////////////////
    // drain path
    ////////////////////////////////////////

    // one word per cycle while the region has data and egress has room
    assign move     = (fill[rd_port] != '0) && !eg_almost_full;
    assign eg_valid = move;
    assign eg_word  = '{port: rd_port, word: mem[rd_addr]};

    // credit back to the packer for each word moved
    always_comb
    begin
        free = '0;
        free[rd_port] = move;
    end

    always_comb
    begin
        wr_hit = '0;
        if (bw_en)
            wr_hit[bw_port] = 1'b1;
    end

    ////////////////////////////////////////
    // ring pointers
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int p = 0; p < NUM; p++)
            begin
                head[p] <= '0;
                tail[p] <= '0;
                fill[p] <= '0;
            end
        end
        else
        begin
            for (int p = 0; p < NUM; p++)
            begin
                // offsets wrap at the region size
                if (wr_hit[p])
                    tail[p] <= tail[p] + 1'b1;
                if (free[p])
                    head[p] <= head[p] + 1'b1;
                case ({wr_hit[p], free[p]})
                    2'b10:   fill[p] <= fill[p] + 1'b1;
                    2'b01:   fill[p] <= fill[p] - 1'b1;
                    default: fill[p] <= fill[p];
                endcase
            end
        end
    end

    // admission already reserved the space
    always_ff @(posedge clk)
    begin
        if (bw_en)
            mem[wr_addr] <= bw_word;
    end

endmodule

// ==== project.f ====
+incdir+.
stream_pkg.sv
buffer_pkg.sv
word_fifo.sv
stream_packer.sv
buffer_arbiter.sv
packet_buffer.sv
sram_fifo_top.sv
tb_clock_gen.sv
tb_sram_fifo.sv

// ==== sram_fifo_params.svh ====
// shared size macros for the two-port packet buffer front end
`ifndef SRAM_FIFO_PARAMS_SVH
`define SRAM_FIFO_PARAMS_SVH

// ingress ports sharing the buffer
`define SF_NUM_PORTS 2
// words in each port's ring region
`define SF_QUEUE_WORDS 64

// stream beat and buffer word data widths
`define SF_BEAT_BITS 32
`define SF_WORD_BITS 24

// small fifos between the stages
`define SF_FIFO_DEPTH 8
// almost full when fewer free slots than this
`define SF_FIFO_MARGIN 3

`endif

// ==== sram_fifo_top.sv ====
// packet buffer front end: two packers and queues, write arbiter, shared buffer and egress fifo
`timescale 1ns/10ps
`include "sram_fifo_params.svh"

module sram_fifo_top
    import stream_pkg::*;
    import buffer_pkg::*;
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic       [`SF_NUM_PORTS-1:0]      s_valid,
    input  beat_data_t [`SF_NUM_PORTS-1:0]      s_data,
    input  pkt_len_t   [`SF_NUM_PORTS-1:0]      s_len,
    input  logic       [`SF_NUM_PORTS-1:0]      s_last,
    output logic       [`SF_NUM_PORTS-1:0]      s_ready,
    input  port_id_t                            rd_port,
    output logic                                m_valid,
    output logic       [`SF_WORD_BITS-1:0]      m_data,
    output logic                                m_last,
    output port_id_t                            m_port,
    input  logic                                m_ready,
    output logic [`SF_NUM_PORTS-1:0][15:0]      drop_count
);

    localparam int NUM = `SF_NUM_PORTS;

    logic      [NUM-1:0] wr_valid;
    mem_word_t [NUM-1:0] wr_word;
    logic      [NUM-1:0] wr_ready;
    logic      [NUM-1:0] wr_almost_full;
    logic      [NUM-1:0] q_valid;
    mem_word_t [NUM-1:0] q_word;
    logic      [NUM-1:0] q_ready;
    logic      [NUM-1:0] free;
    logic                bw_en;
    port_id_t            bw_port;
    mem_word_t           bw_word;
    logic                eg_valid;
    out_word_t           eg_word;
    logic                eg_almost_full;
    out_word_t           m_word;

    ////////////////////////////////////////
    // per-port packer and queue
    ////////////////////////////////////////
    for (genvar p = 0; p < NUM; p++)
    begin : g_port
        stream_packer u_packer (
            .clk            (clk),
            .reset          (reset),
            .s_valid        (s_valid[p]),
            .s_data         (s_data[p]),
            .s_len          (s_len[p]),
            .s_last         (s_last[p]),
            .s_ready        (s_ready[p]),
            .wr_valid       (wr_valid[p]),
            .wr_word        (wr_word[p]),
            .wr_ready       (wr_ready[p]),
            .wr_almost_full (wr_almost_full[p]),
            .free           (free[p]),
            .drop_count     (drop_count[p])
        );

        word_fifo #(.payload_t(mem_word_t)) u_queue (
            .clk         (clk),
            .reset       (reset),
            .in_valid    (wr_valid[p]),
            .in_data     (wr_word[p]),
            .in_ready    (wr_ready[p]),
            .out_valid   (q_valid[p]),
            .out_data    (q_word[p]),
            .out_ready   (q_ready[p]),
            .almost_full (wr_almost_full[p])
        );
    end

    ////////////////////////////////////////
    // shared write port and buffer
    ////////////////////////////////////////
    buffer_arbiter u_arbiter (
        .clk     (clk),
        .reset   (reset),
        .q_valid (q_valid),
        .q_word  (q_word),
        .q_ready (q_ready),
        .bw_en   (bw_en),
        .bw_port (bw_port),
        .bw_word (bw_word)
    );

    packet_buffer u_buffer (
        .clk            (clk),
        .reset          (reset),
        .bw_en          (bw_en),
        .bw_port        (bw_port),
        .bw_word        (bw_word),
        .rd_port        (rd_port),
        .eg_valid       (eg_valid),
        .eg_word        (eg_word),
        .eg_almost_full (eg_almost_full),
        .free           (free)
    );

    // egress, never full thanks to the margin
    word_fifo #(.payload_t(out_word_t)) u_egress (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (eg_valid),
        .in_data     (eg_word),
        .in_ready    (),
        .out_valid   (m_valid),
        .out_data    (m_word),
        .out_ready   (m_ready),
        .almost_full (eg_almost_full)
    );

    // split the egress word onto the output pins
    assign m_data = m_word.word.data;
    assign m_last = m_word.word.last;
    assign m_port = m_word.port;

endmodule

// ==== stream_packer.sv ====
// per-port packer: admits or drops whole packets and repacks 32-bit beats into 24-bit words
`timescale 1ns/10ps
`include "sram_fifo_params.svh"

module stream_packer
    import stream_pkg::*;
    import buffer_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        s_valid,
    input  beat_data_t  s_data,
    input  pkt_len_t    s_len,
    input  logic        s_last,
    output logic        s_ready,
    output logic        wr_valid,
    output mem_word_t   wr_word,
    input  logic        wr_ready,
    input  logic        wr_almost_full,
    input  logic        free,
    output logic [15:0] drop_count
);

    logic [1:0]  phase;
    logic [1:0]  next_phase;
    beat_data_t  prev_data;
    logic        prev_last;
    logic        running;
    logic        first_beat;
    logic        admit_q;
    credit_t     credit;
    credit_t     reserve;
    logic [15:0] need;
    logic        fits;
    logic        admit_now;
    logic        take;
    logic        store;
    logic        hold;
    logic        flush_pending;
    logic        next_valid;
    mem_word_t   next_word;

    ////////////////////////////////////////
    // handshakes and admission
    ////////////////////////////////////////

    // output word not yet taken by the queue
    assign hold = wr_valid && !wr_ready;
    // leftover bytes of a finished packet still to go out
    assign flush_pending = prev_last && ((phase == 2'd1) || (phase == 2'd2));

    // no beat in phase 3, during a flush or while the queue fills
    assign s_ready = running && (phase != 2'd3) && !flush_pending
                     && !wr_almost_full && !hold;
    assign take = s_valid && s_ready;

    // words needed for the packet, ceil(len/3)
    assign need = (s_len + 16'd2) / 16'd3;
    assign fits = (16'(credit) >= need);
    // decision made on the first beat, kept for the rest
    assign admit_now = first_beat ? fits : admit_q;
    assign store = take && admit_now;
    // whole packet reserved at admission
    assign reserve = (take && first_beat && fits) ? credit_t'(need) : '0;

    ////////////////////////////////////////
    // repacking
    ////////////////////////////////////////
    always_comb
    begin
        next_valid = 1'b0;
        next_phase = phase;
        next_word.data  = '0;
        next_word.phase = phase;
        next_word.last  = 1'b0;
        if (!hold)
        begin
            if (phase == 2'd3)
            begin
                // stall word, upper three bytes of the held beat
                next_valid = 1'b1;
                next_word.data = prev_data[31:8];
                next_word.last = prev_last;
                next_phase = 2'd0;
            end
            else if (store)
            begin
                next_valid = 1'b1;
                next_phase = phase + 2'd1;
                case (phase)
                    2'd0:    next_word.data = s_data[23:0];
                    2'd1:    next_word.data = {s_data[15:0], prev_data[31:24]};
                    default: next_word.data = {s_data[7:0], prev_data[31:16]};
                endcase
            end
            else if (flush_pending)
            begin
                // zero padded tail
                next_valid = 1'b1;
                next_word.last = 1'b1;
                next_phase = 2'd0;
                if (phase == 2'd1)
                    next_word.data = {16'd0, prev_data[31:24]};
                else
                    next_word.data = {8'd0, prev_data[31:16]};
            end
        end
    end

    ////////////////////////////////////////
    // control state
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            running    <= 1'b0;
            phase      <= 2'd0;
            prev_last  <= 1'b0;
            first_beat <= 1'b1;
            admit_q    <= 1'b0;
            wr_valid   <= 1'b0;
            credit     <= credit_t'(`SF_QUEUE_WORDS);
            drop_count <= '0;
        end
        else
        begin
            running <= 1'b1;
            phase   <= next_phase;
            if (!hold)
                wr_valid <= next_valid;
            if (store)
                prev_last <= s_last;
            if (take)
            begin
                first_beat <= s_last;
                if (first_beat)
                    admit_q <= fits;
            end
            // one word back per buffer read
            credit <= credit - reserve + credit_t'(free);
            // count a drop once, on its last beat
            if (take && s_last && !admit_now)
                drop_count <= drop_count + 16'd1;
        end
    end

    // payload registers
    always_ff @(posedge clk)
    begin
        if (store)
            prev_data <= s_data;
        if (!hold && next_valid)
            wr_word <= next_word;
    end

endmodule

// ==== stream_pkg.sv ====
// ingress stream types: beat data, packet length and port index
`include "sram_fifo_params.svh"

package stream_pkg;

    // one full stream beat, no byte strobes
    typedef logic [`SF_BEAT_BITS-1:0] beat_data_t;

    // packet length in bytes, multiple of 4
    // only looked at on the first beat
    typedef logic [15:0] pkt_len_t;

    // which ingress port a word belongs to
    typedef logic [$clog2(`SF_NUM_PORTS)-1:0] port_id_t;

endpackage

// ==== tb_clock_gen.sv ====
// testbench clock source, 100 ns period, with a synchronous reset held for 10 cycles
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 50 ns high, 50 ns low
    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial
    begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== tb_sram_fifo.sv ====
// table-driven testbench for the two-port packet buffer front end
`timescale 1ns/10ps
`include "sram_fifo_params.svh"

module tb_sram_fifo
    import stream_pkg::*;
    import buffer_pkg::*;
;

    localparam int NUM = `SF_NUM_PORTS;
    localparam int WAIT_LIMIT = 2000;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;
    localparam int NROWS = 12;

    // one table row: what to send and how to drain it
    typedef struct packed {
        int port;
        int beats;
        int npkt;
        int both;
        int rd;
        int toggle;
        int drain;
    } row_t;

    //////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////
    // port, beats, packets, both ports, rd_port, m_ready toggle, drain
    row_t rows [NROWS] = '{
        '{0, 1, 1, 0, 0, 0, 1},
        '{0, 2, 1, 0, 0, 0, 1},
        '{0, 3, 1, 0, 0, 0, 1},
        '{0, 4, 1, 0, 0, 0, 1},
        '{0, 5, 1, 0, 0, 0, 1},
        '{0, 6, 1, 0, 0, 0, 1},
        '{0, 5, 2, 1, 0, 0, 1},
        // 8 packets of 8 words fill the region, 2 more are dropped
        '{0, 6, 10, 0, 1, 0, 0},
        '{0, 0, 0, 0, 0, 0, 1},
        '{0, 6, 1, 0, 0, 0, 1},
        '{1, 12, 3, 0, 1, 1, 1},
        '{0, 8, 2, 1, 1, 1, 1}
    };
    string names [NROWS] = '{
        "len_1", "len_2", "len_3", "len_4", "len_5", "len_6",
        "both_ports", "fill_port0", "drain_port0", "reuse_credit",
        "ready_toggle", "both_toggle"
    };

    logic                         clk;
    logic                         reset;
    logic       [NUM-1:0]         s_valid;
    beat_data_t [NUM-1:0]         s_data;
    pkt_len_t   [NUM-1:0]         s_len;
    logic       [NUM-1:0]         s_last;
    logic       [NUM-1:0]         s_ready;
    port_id_t                     rd_port;
    logic                         m_valid;
    logic [`SF_WORD_BITS-1:0]     m_data;
    logic                         m_last;
    port_id_t                     m_port;
    logic                         m_ready = 1'b0;
    logic [NUM-1:0][15:0]         drop_count;

    // reference model state per port
    mem_word_t   exp_q [NUM][$];
    int          credit [NUM];
    logic [15:0] drops [NUM];
    logic [15:0] lfsr_state = 16'd48722;
    string       cur_name = "reset";
    logic        toggle_mode = 1'b0;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    sram_fifo_top u_sram_fifo_top (
        .clk        (clk),
        .reset      (reset),
        .s_valid    (s_valid),
        .s_data     (s_data),
        .s_len      (s_len),
        .s_last     (s_last),
        .s_ready    (s_ready),
        .rd_port    (rd_port),
        .m_valid    (m_valid),
        .m_data     (m_data),
        .m_last     (m_last),
        .m_port     (m_port),
        .m_ready    (m_ready),
        .drop_count (drop_count)
    );

    task automatic report_failure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int count);
        logic [31:0] value;
        logic        out_bit;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            out_bit = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit)
                lfsr_state = lfsr_state ^ LFSR_TAPS;
            value = {value[30:0], out_bit};
        end
        return value;
    endfunction

    //////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////
    task automatic check_word(input string name, input mem_word_t exp, input mem_word_t act);
        if (act.data !== exp.data || act.last !== exp.last)
        begin
            $display("[ERROR] %s: expected data %h last %0b, actual data %h last %0b",
                     name, exp.data, exp.last, act.data, act.last);
            report_failure();
        end
    endtask

    task automatic check_port(input string name, input port_id_t exp, input port_id_t act);
        if (act !== exp)
        begin
            $display("[ERROR] %s: expected port %0d, actual port %0d", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_drops(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        if (act !== exp)
        begin
            $display("[ERROR] %s: expected drops %0d, actual drops %0d", name, exp, act);
            report_failure();
        end
    endtask

    //////////////////////////////////////////
    // ingress driver and model
    //////////////////////////////////////////
    task automatic send_packet(input int p, input int beats);
        beat_data_t data_q[$];
        logic [7:0] bytes_q[$];
        mem_word_t  word;
        int         nbytes;
        int         need;
        int         cnt;
        nbytes = 4 * beats;
        need = (nbytes + 2) / 3;
        for (int k = 0; k < beats; k++)
            data_q.push_back(lfsr_bits(32));
        // whole packet admitted only if the region has room for it
        if (credit[p] >= need)
        begin
            credit[p] -= need;
            for (int k = 0; k < beats; k++)
                for (int b = 0; b < 4; b++)
                    bytes_q.push_back(data_q[k][8*b +: 8]);
            // bytes in order, three per word, zero padded tail
            for (int w = 0; w < need; w++)
            begin
                word = '0;
                for (int i = 0; i < 3; i++)
                    if (3*w + i < nbytes)
                        word.data[8*i +: 8] = bytes_q[3*w + i];
                word.last = (w == need - 1);
                exp_q[p].push_back(word);
            end
        end
        else
            drops[p] = drops[p] + 16'd1;
        for (int k = 0; k < beats; k++)
        begin
            s_valid[p] = 1'b1;
            s_data[p]  = data_q[k];
            s_len[p]   = pkt_len_t'(nbytes);
            s_last[p]  = (k == beats - 1);
            cnt = 0;
            // ready is registered state, stable on the falling edge
            while (s_ready[p] !== 1'b1)
            begin
                if (cnt == WAIT_LIMIT)
                begin
                    $display("timeout: port %0d never took a beat in %s", p, cur_name);
                    report_failure();
                end
                cnt++;
                @(negedge clk);
            end
            @(negedge clk);
        end
        s_valid[p] = 1'b0;
        s_last[p]  = 1'b0;
    endtask

    task automatic send_burst(input int p, input int beats, input int npkt);
        for (int i = 0; i < npkt; i++)
            send_packet(p, beats);
    endtask

    // reader stays on a port until every expected word of it arrived
    task automatic drain_ports(input int first);
        int p;
        int cnt;
        for (int i = 0; i < NUM; i++)
        begin
            p = (first + i) % NUM;
            rd_port = port_id_t'(p);
            cnt = 0;
            while (exp_q[p].size() != 0)
            begin
                if (cnt == WAIT_LIMIT)
                begin
                    $display("timeout: port %0d did not drain in %s", p, cur_name);
                    report_failure();
                end
                cnt++;
                @(negedge clk);
            end
        end
    endtask

    //////////////////////////////////////////
    // egress monitor
    //////////////////////////////////////////
    always @(negedge clk)
    begin : monitor
        mem_word_t   exp_word;
        mem_word_t   got_word;
        port_id_t    src;
        logic [31:0] rnd;
        if (reset)
            m_ready = 1'b0;
        else
        begin
            if (toggle_mode)
            begin
                rnd = lfsr_bits(1);
                m_ready = rnd[0];
            end
            else
                m_ready = 1'b1;
            // word taken on the coming rising edge
            if (m_valid && m_ready)
            begin
                src = rd_port;
                check_port(cur_name, src, m_port);
                if (exp_q[src].size() == 0)
                begin
                    $display("extra output word on port %0d in %s", src, cur_name);
                    report_failure();
                end
                exp_word = exp_q[src].pop_front();
                got_word = '{data: m_data, phase: exp_word.phase, last: m_last};
                check_word(cur_name, exp_word, got_word);
                // credit comes back once the word left the buffer
                credit[src]++;
            end
        end
    end

    initial
    begin : main
        int cnt;
        s_valid = '0;
        s_data  = '0;
        s_len   = '0;
        s_last  = '0;
        rd_port = '0;
        for (int p = 0; p < NUM; p++)
        begin
            credit[p] = `SF_QUEUE_WORDS;
            drops[p]  = '0;
        end
        cnt = 0;
        while (reset !== 1'b0)
        begin
            if (cnt == WAIT_LIMIT)
            begin
                $display("timeout: reset never released");
                report_failure();
            end
            cnt++;
            @(negedge clk);
        end
        @(negedge clk);
        // idle outputs straight after reset
        if (m_valid !== 1'b0)
        begin
            $display("[ERROR] after_reset: expected m_valid 0, actual m_valid %0b", m_valid);
            report_failure();
        end
        for (int p = 0; p < NUM; p++)
            check_drops("after_reset", 16'd0, drop_count[p]);

        for (int r = 0; r < NROWS; r++)
        begin
            cur_name = names[r];
            toggle_mode = (rows[r].toggle != 0);
            rd_port = port_id_t'(rows[r].rd);
            if (rows[r].both != 0)
                fork
                    send_burst(0, rows[r].beats, rows[r].npkt);
                    send_burst(1, rows[r].beats, rows[r].npkt);
                join
            else
                send_burst(rows[r].port, rows[r].beats, rows[r].npkt);
            if (rows[r].drain != 0)
                drain_ports(rows[r].rd);
            for (int p = 0; p < NUM; p++)
                check_drops(names[r], drops[p], drop_count[p]);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== word_fifo.sv ====
// small synchronous fifo with a typed payload and an almost-full flag
`timescale 1ns/10ps
`include "sram_fifo_params.svh"

module word_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready,
    output logic     almost_full
);

    localparam int unsigned DEPTH    = `SF_FIFO_DEPTH;
    localparam int unsigned PTR_BITS = $clog2(DEPTH);
    // count above this leaves fewer than SF_FIFO_MARGIN free
    localparam logic [PTR_BITS:0] AF_LEVEL = (PTR_BITS+1)'(DEPTH - `SF_FIFO_MARGIN);
    localparam logic [PTR_BITS:0] FULL_LEVEL = (PTR_BITS+1)'(DEPTH);
    localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(DEPTH - 1);

    payload_t            store [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                push;
    logic                pop;

    // flags straight from the count
    assign in_ready    = (count != FULL_LEVEL);
    assign out_valid   = (count != '0);
    assign almost_full = (count > AF_LEVEL);

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // head entry always visible
    assign out_data = store[rd_ptr];

    ////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            // push and pop together leave count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk)
    begin
        if (push)
            store[wr_ptr] <= in_data;
    end

endmodule
